/* vlog.f */
+incdir+tb
logic/tdc_pkg.sv
logic/phase_decoder.sv
logic/measure_window.sv
logic/hit_capture.sv
logic/tof_calc.sv
logic/frame_emitter.sv
logic/tdc_top.sv
tb/tdc_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the TDC testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tdc_tb \
    -Mdir obj_dir -o tdc_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tdc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation finished: PASS$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* tb/tdc_ref.svh */
`ifndef TDC_REF_SVH
`define TDC_REF_SVH

// ------------------------------------------------
// reference model of the TDC result rules
// ------------------------------------------------

// taps set from bit 0 up to the first zero, capped at the top code
function automatic int fine_code_of(input logic [PHASE_W-1:0] ph);
    logic [PHASE_W-1:0] zeros;
    int                 first_zero;
    zeros      = ~ph;
    first_zero = PHASE_W;  // no zero at all
    for (int i = PHASE_W - 1; i >= 0; i--) begin
        if (zeros[i]) begin
            first_zero = i;
        end
    end
    if (first_zero > (1 << FINE_W) - 1) begin
        return (1 << FINE_W) - 1;
    end
    return first_zero;
endfunction

// coarse steps of 32 taps, stop fine minus start fine
function automatic logic [TOF_W-1:0] expected_tof(input int coarse,
                                                  input logic [PHASE_W-1:0] stop_ph,
                                                  input logic [PHASE_W-1:0] start_ph,
                                                  input logic [TOF_W-1:0] rng);
    int t;
    t = 32 * coarse + fine_code_of(stop_ph) - fine_code_of(start_ph);
    if (t < 0 || t > int'(rng)) begin
        return TOF_OVERFLOW;
    end
    return TOF_W'(t);
endfunction

// enabled SPADs, saturated
function automatic logic [INT_W-1:0] spad_intensity(input logic [SPAD_W-1:0] sp);
    int ones;
    ones = 0;
    for (int i = 0; i < SPAD_W; i++) begin
        if (sp[i]) begin
            ones = ones + 1;
        end
    end
    if (ones > int'(INT_MAX)) begin
        return INT_MAX;
    end
    return INT_W'(ones);
endfunction

`endif

/* tb/tdc_tb.sv */
`timescale 1ns/1ps

module tdc_tb
    import tdc_pkg::*;
;

    localparam int MAX_HITS     = 3;
    localparam int NUM_FRAMES   = 7 + 30;
    localparam int FRAME_CYCLES = (1 << COARSE_W) + 64;  // longest window plus drain
    localparam int MAX_CYCLES   = NUM_FRAMES * FRAME_CYCLES + 500;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               start_i;
    logic               hit_i;
    logic [PHASE_W-1:0] phase_i;
    logic [SPAD_W-1:0]  spad_en_i;
    logic [TOF_W-1:0]   range_i;
    logic               tdc_ready_i;
    logic               tdc_valid_o;
    logic [TOF_W-1:0]   tdc_data_o;
    logic [INT_W-1:0]   tdc_int_o;
    logic [NUM_W-1:0]   tdc_num_o;
    logic               tdc_last_o;
    logic               busy_o;

    int seed       = 37;
    int ready_seed = 37;
    bit ready_rand = 1'b0;
    int errors     = 0;
    int checks     = 0;
    int frames_done = 0;
    int cycles     = 0;
    logic [31:0] ready_rv;

    // hits of the next frame, coarse step -1 means before start
    int                 hit_c[$];
    logic [PHASE_W-1:0] hit_ph[$];
    logic [SPAD_W-1:0]  hit_sp[$];

    // expected beats in order
    logic [TOF_W-1:0] exp_data[$];
    logic [INT_W-1:0] exp_int[$];
    logic [NUM_W-1:0] exp_num[$];
    bit               exp_last[$];
    logic [TOF_W-1:0] e_data;
    logic [INT_W-1:0] e_int;
    logic [NUM_W-1:0] e_num;
    bit               e_last;

    `include "tdc_ref.svh"

    tdc_top #(.MAX_HITS(MAX_HITS)) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .hit_i       (hit_i),
        .phase_i     (phase_i),
        .spad_en_i   (spad_en_i),
        .range_i     (range_i),
        .tdc_ready_i (tdc_ready_i),
        .tdc_valid_o (tdc_valid_o),
        .tdc_data_o  (tdc_data_o),
        .tdc_int_o   (tdc_int_o),
        .tdc_num_o   (tdc_num_o),
        .tdc_last_o  (tdc_last_o),
        .busy_o      (busy_o)
    );

    always #4 clk = ~clk;

    always @(negedge clk) begin
        ready_rv = $random(ready_seed);
        tdc_ready_i = ready_rand ? ready_rv[0] : 1'b1;
    end

    // ------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------
    function automatic logic [PHASE_W-1:0] thermo_phase(input int k,
                                                        input logic [PHASE_W-1:0] junk);
        logic [PHASE_W-1:0] p;
        p = junk;  // taps above the first zero are don't care
        for (int i = 0; i < PHASE_W; i++) begin
            if (i < k) begin
                p[i] = 1'b1;
            end else if (i == k) begin
                p[i] = 1'b0;
            end
        end
        return p;
    endfunction

    function automatic logic [PHASE_W-1:0] random_phase();
        int                 k;
        logic [PHASE_W-1:0] junk;
        k    = $unsigned($random(seed)) % (PHASE_W + 1);
        junk = $random(seed);
        return thermo_phase(k, junk);
    endfunction

    function automatic logic [SPAD_W-1:0] random_spad();
        logic [31:0] v;
        v = $random(seed);
        if (v[2:0] == 3'd0) begin
            return '1;
        end
        return v[31:16];
    endfunction

    task automatic add_hit(input int c, input logic [PHASE_W-1:0] ph,
                           input logic [SPAD_W-1:0] sp);
        hit_c.push_back(c);
        hit_ph.push_back(ph);
        hit_sp.push_back(sp);
    endtask

    // one measurement: predict the beats, drive start and hits, wait for the frame
    task automatic run_frame(input logic [TOF_W-1:0] rng, input logic [PHASE_W-1:0] sph,
                             input bit poke_busy);
        int r;
        int last_c;
        int taken;
        int target;
        bit poked;
        r      = int'(rng[TOF_W-1:FINE_W]);
        last_c = r + 1;  // one step past close, the count report cycle
        taken  = 0;
        poked  = 1'b0;
        target = frames_done + 1;
        foreach (hit_c[i]) begin
            if (hit_c[i] > last_c) begin
                last_c = hit_c[i];
            end
            if (hit_c[i] >= 0 && hit_c[i] <= r && taken < MAX_HITS) begin
                exp_data.push_back(expected_tof(hit_c[i], hit_ph[i], sph, rng));
                exp_int.push_back(spad_intensity(hit_sp[i]));
                taken++;
            end
        end
        for (int i = 0; i < taken; i++) begin
            exp_num.push_back(NUM_W'(taken));
            exp_last.push_back(i == taken - 1);
        end
        if (taken == 0) begin  // empty frame beat
            exp_data.push_back(TOF_OVERFLOW);
            exp_int.push_back('0);
            exp_num.push_back('0);
            exp_last.push_back(1'b1);
        end
        if (hit_c.size() > 0 && hit_c[0] < 0) begin
            hit_i     = 1'b1;
            phase_i   = hit_ph[0];
            spad_en_i = hit_sp[0];
            @(negedge clk);
            hit_i = 1'b0;
        end
        start_i = 1'b1;
        range_i = rng;
        phase_i = sph;
        @(negedge clk);
        start_i = 1'b0;
        for (int c = 0; c <= last_c; c++) begin  // coarse count is c here
            // idle while the window runs, busy from the count report on
            if (c <= r + 1 && busy_o !== (c > r)) begin
                $display("error at %0t: busy_o = %b, expected %b", $time, busy_o, c > r);
                errors++;
            end
            foreach (hit_c[i]) begin
                if (hit_c[i] == c) begin
                    hit_i     = 1'b1;
                    phase_i   = hit_ph[i];
                    spad_en_i = hit_sp[i];
                end
            end
            @(negedge clk);
            hit_i = 1'b0;
        end
        while (frames_done < target) begin
            if (poke_busy && !poked && busy_o) begin
                start_i = 1'b1;
                range_i = '0;  // a wrong accept gives a quick empty frame
                poked   = 1'b1;
            end
            @(negedge clk);
            start_i = 1'b0;
        end
        if (poke_busy && !poked) begin
            $display("start while busy was never driven, busy_o stayed low");
            errors++;
        end
        hit_c.delete();
        hit_ph.delete();
        hit_sp.delete();
    endtask

    task automatic random_frame();
        logic [TOF_W-1:0] rng;
        int               r;
        int               n;
        int               gap;
        int               c;
        rng = TOF_W'($random(seed));
        r   = int'(rng[TOF_W-1:FINE_W]);
        n   = $unsigned($random(seed)) % 6;
        gap = (r + 2) / (n + 1) + 1;
        c   = -1;
        if ($unsigned($random(seed)) % 4 == 0) begin
            add_hit(-1, random_phase(), random_spad());
        end
        for (int i = 0; i < n; i++) begin
            c = c + 1 + $unsigned($random(seed)) % gap;  // may land after close
            add_hit(c, random_phase(), random_spad());
        end
        run_frame(rng, random_phase(), 1'b0);
    endtask

    // ------------------------------------------------
    // compare every handshake with the next expected beat
    // ------------------------------------------------
    always @(posedge clk) begin
        if (rst_n && tdc_valid_o && tdc_ready_i) begin
            if (busy_o !== 1'b1) begin
                $display("error at %0t: busy_o = %b, expected 1", $time, busy_o);
                errors++;
            end
            if (exp_data.size() == 0) begin
                $display("unexpected beat at %0t, no frame was pending", $time);
                errors++;
            end else begin
                e_data = exp_data.pop_front();
                e_int  = exp_int.pop_front();
                e_num  = exp_num.pop_front();
                e_last = exp_last.pop_front();
                checks++;
                if (tdc_data_o !== e_data) begin
                    $display("error at %0t: tdc_data_o = %h, expected %h",
                             $time, tdc_data_o, e_data);
                    errors++;
                end
                if (tdc_int_o !== e_int) begin
                    $display("error at %0t: tdc_int_o = %h, expected %h",
                             $time, tdc_int_o, e_int);
                    errors++;
                end
                if (tdc_num_o !== e_num) begin
                    $display("error at %0t: tdc_num_o = %h, expected %h",
                             $time, tdc_num_o, e_num);
                    errors++;
                end
                if (tdc_last_o !== e_last) begin
                    $display("error at %0t: tdc_last_o = %b, expected %b",
                             $time, tdc_last_o, e_last);
                    errors++;
                end
            end
            if (tdc_last_o) begin
                frames_done++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, frame %0d never completed", cycles, frames_done);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------
    // test sequence
    // ------------------------------------------------
    initial begin
        rst_n       = 1'b0;
        start_i     = 1'b0;
        hit_i       = 1'b0;
        phase_i     = '0;
        spad_en_i   = '0;
        range_i     = '0;
        tdc_ready_i = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // three hits in order
        add_hit(5, thermo_phase(10, '0), 16'h00F0);
        add_hit(12, thermo_phase(0, '1), 16'h0001);
        add_hit(30, thermo_phase(31, '0), 16'hFFFF);
        run_frame(15'd1600, thermo_phase(3, '0), 1'b0);

        run_frame(15'd200, thermo_phase(7, '0), 1'b0);  // no hits

        // one hit before start, five in the window, one after close
        add_hit(-1, thermo_phase(2, '0), 16'h0F0F);
        add_hit(0, thermo_phase(9, '0), 16'h0011);
        add_hit(2, thermo_phase(18, '1), 16'h7000);
        add_hit(4, thermo_phase(25, '0), 16'h00FF);
        add_hit(6, thermo_phase(1, '0), 16'hAAAA);
        add_hit(10, thermo_phase(4, '0), 16'h5555);
        add_hit(12, thermo_phase(6, '0), 16'h1234);
        run_frame(15'd320, thermo_phase(5, '0), 1'b0);

        // negative and over-range TOF, hit on the closing step
        add_hit(0, thermo_phase(1, '0), 16'h0003);
        add_hit(1, thermo_phase(6, '0), 16'hFFFF);
        add_hit(2, thermo_phase(14, '0), 16'h8000);
        run_frame(15'd70, thermo_phase(4, '0), 1'b0);

        // back-pressure from here on
        @(posedge clk);
        ready_rand = 1'b1;
        @(negedge clk);
        add_hit(3, thermo_phase(12, '0), 16'h0101);
        add_hit(8, thermo_phase(32, '0), 16'hFFFF);
        add_hit(20, thermo_phase(20, '1), 16'h0000);
        run_frame(15'd900, thermo_phase(0, '0), 1'b1);
        run_frame(15'd64, thermo_phase(8, '0), 1'b1);
        add_hit(1, thermo_phase(16, '0), 16'h00C3);
        run_frame(15'd100, thermo_phase(2, '0), 1'b1);

        for (int f = 0; f < 30; f++) begin
            random_frame();
        end
        repeat (40) @(negedge clk);

        if (exp_data.size() != 0) begin
            $display("%0d expected beats were never sent", exp_data.size());
            errors++;
        end
        $display("frames %0d, beats checked %0d, errors %0d", frames_done, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* logic/tdc_top.sv */
`timescale 1ns/1ps

module tdc_top
    import tdc_pkg::*;
#(
    parameter int MAX_HITS = 3
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_i,
    input  logic               hit_i,
    input  logic [PHASE_W-1:0] phase_i,
    input  logic [SPAD_W-1:0]  spad_en_i,
    input  logic [TOF_W-1:0]   range_i,
    input  logic               tdc_ready_i,
    output logic               tdc_valid_o,
    output logic [TOF_W-1:0]   tdc_data_o,
    output logic [INT_W-1:0]   tdc_int_o,
    output logic [NUM_W-1:0]   tdc_num_o,
    output logic               tdc_last_o,
    output logic               busy_o
);

    // ------------------------------------------------
    // window to capture
    // ------------------------------------------------
    logic                window_open;
    logic                window_close;
    logic [COARSE_W-1:0] coarse;
    logic [TOF_W-1:0]    range;
    logic [PHASE_W-1:0]  start_phase;

    // capture to pipeline and emitter
    logic [NUM_W-1:0]    hit_count;
    logic                count_valid;
    logic                hit_valid;
    logic [COARSE_W-1:0] hit_coarse;
    logic [PHASE_W-1:0]  hit_phase;
    logic [SPAD_W-1:0]   hit_spad;

    // pipeline to emitter
    logic                res_valid;
    logic [TOF_W-1:0]    res_tof;
    logic [INT_W-1:0]    res_int;

    measure_window u_window (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start_i),
        .range_i        (range_i),
        .phase_i        (phase_i),
        .busy_i         (busy_o),
        .window_open_o  (window_open),
        .coarse_o       (coarse),
        .window_close_o (window_close),
        .range_o        (range),
        .start_phase_o  (start_phase)
    );

    hit_capture #(.MAX_HITS(MAX_HITS)) u_capture (
        .clk            (clk),
        .rst_n          (rst_n),
        .hit_i          (hit_i),
        .spad_en_i      (spad_en_i),
        .phase_i        (phase_i),
        .window_open_i  (window_open),
        .window_close_i (window_close),
        .coarse_i       (coarse),
        .hit_count_o    (hit_count),
        .count_valid_o  (count_valid),
        .hit_valid_o    (hit_valid),
        .hit_coarse_o   (hit_coarse),
        .hit_phase_o    (hit_phase),
        .hit_spad_o     (hit_spad)
    );

    tof_calc u_calc (
        .clk           (clk),
        .rst_n         (rst_n),
        .hit_valid_i   (hit_valid),
        .hit_coarse_i  (hit_coarse),
        .hit_phase_i   (hit_phase),
        .hit_spad_i    (hit_spad),
        .start_phase_i (start_phase),
        .range_i       (range),
        .res_valid_o   (res_valid),
        .res_tof_o     (res_tof),
        .res_int_o     (res_int)
    );

    frame_emitter #(.MAX_HITS(MAX_HITS)) u_emitter (
        .clk           (clk),
        .rst_n         (rst_n),
        .count_valid_i (count_valid),
        .hit_count_i   (hit_count),
        .res_valid_i   (res_valid),
        .res_tof_i     (res_tof),
        .res_int_i     (res_int),
        .tdc_ready_i   (tdc_ready_i),
        .tdc_valid_o   (tdc_valid_o),
        .tdc_data_o    (tdc_data_o),
        .tdc_int_o     (tdc_int_o),
        .tdc_num_o     (tdc_num_o),
        .tdc_last_o    (tdc_last_o),
        .busy_o        (busy_o)
    );

endmodule

/* logic/frame_emitter.sv */
`timescale 1ns/1ps

module frame_emitter
    import tdc_pkg::*;
#(
    parameter int MAX_HITS = 3
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             count_valid_i,
    input  logic [NUM_W-1:0] hit_count_i,
    input  logic             res_valid_i,
    input  logic [TOF_W-1:0] res_tof_i,
    input  logic [INT_W-1:0] res_int_i,
    input  logic             tdc_ready_i,
    output logic             tdc_valid_o,
    output logic [TOF_W-1:0] tdc_data_o,
    output logic [INT_W-1:0] tdc_int_o,
    output logic [NUM_W-1:0] tdc_num_o,
    output logic             tdc_last_o,
    output logic             busy_o
);

    logic [TOF_W-1:0] tof_buf [MAX_HITS];
    logic [INT_W-1:0] int_buf [MAX_HITS];

    logic [NUM_W-1:0] expect_q;   // hits in this frame
    logic [NUM_W-1:0] got_q;      // results buffered so far
    logic [NUM_W-1:0] rd_idx_q;   // beat being offered
    logic             collect_q;
    logic             valid_q;
    logic             busy_q;
    logic             empty;
    logic             last_beat;
    logic             hs;

    assign empty     = (expect_q == '0);
    assign last_beat = empty || (rd_idx_q == expect_q - 1'b1);
    assign hs        = valid_q && tdc_ready_i;

    // ------------------------------------------------
    // result buffer, filled in hit order
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (res_valid_i) begin
            tof_buf[got_q] <= res_tof_i;
            int_buf[got_q] <= res_int_i;
        end
    end

    // ------------------------------------------------
    // frame control
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            expect_q  <= '0;
            got_q     <= '0;
            rd_idx_q  <= '0;
            collect_q <= 1'b0;
            valid_q   <= 1'b0;
            busy_q    <= 1'b0;
        end else begin
            if (count_valid_i) begin
                expect_q  <= hit_count_i;
                got_q     <= '0;
                collect_q <= 1'b1;
                busy_q    <= 1'b1;
            end
            if (res_valid_i) begin
                got_q <= got_q + 1'b1;
            end
            // whole frame buffered, start offering beats
            if (collect_q && (got_q == expect_q)) begin
                collect_q <= 1'b0;
                valid_q   <= 1'b1;
                rd_idx_q  <= '0;
            end
            if (hs) begin
                if (last_beat) begin
                    valid_q <= 1'b0;
                    busy_q  <= 1'b0;  // frame done
                end else begin
                    rd_idx_q <= rd_idx_q + 1'b1;
                end
            end
        end
    end

    // beat fields only move on a handshake
    assign tdc_valid_o = valid_q;
    assign tdc_data_o  = empty ? TOF_OVERFLOW : tof_buf[rd_idx_q];
    assign tdc_int_o   = empty ? '0 : int_buf[rd_idx_q];
    assign tdc_num_o   = expect_q;
    assign tdc_last_o  = valid_q && last_beat;
    assign busy_o      = busy_q || count_valid_i;  // covers the report cycle too

    a_beat_stable: assert property (@(posedge clk) disable iff (!rst_n)
        tdc_valid_o && !tdc_ready_i |=> tdc_valid_o && $stable(tdc_data_o)
            && $stable(tdc_int_o) && $stable(tdc_num_o) && $stable(tdc_last_o));

endmodule

/* logic/tof_calc.sv */
`timescale 1ns/1ps

module tof_calc
    import tdc_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                hit_valid_i,
    input  logic [COARSE_W-1:0] hit_coarse_i,
    input  logic [PHASE_W-1:0]  hit_phase_i,
    input  logic [SPAD_W-1:0]   hit_spad_i,
    input  logic [PHASE_W-1:0]  start_phase_i,
    input  logic [TOF_W-1:0]    range_i,
    output logic                res_valid_o,
    output logic [TOF_W-1:0]    res_tof_o,
    output logic [INT_W-1:0]    res_int_o
);

    logic [FINE_W-1:0]     start_fine;
    logic [FINE_W-1:0]     stop_fine;
    logic signed [TOF_W:0] diff;      // sign bit for stop before start
    logic [POP_W-1:0]      pop;

    logic                  s1_valid_q;
    logic signed [TOF_W:0] s1_diff_q;
    logic [POP_W-1:0]      s1_pop_q;
    logic                  s2_valid_q;

    phase_decoder u_start_dec (
        .phase_i (start_phase_i),
        .fine_o  (start_fine)
    );

    phase_decoder u_stop_dec (
        .phase_i (hit_phase_i),
        .fine_o  (stop_fine)
    );

    // ------------------------------------------------
    // stage 1: fine codes and popcount
    // ------------------------------------------------
    assign diff = $signed({1'b0, hit_coarse_i, stop_fine})
                - $signed({{(TOF_W - FINE_W + 1){1'b0}}, start_fine});

    always_comb begin
        pop = '0;
        for (int i = 0; i < SPAD_W; i++) begin
            pop = pop + POP_W'(hit_spad_i[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= hit_valid_i;
            s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_valid_i) begin
            s1_diff_q <= diff;
            s1_pop_q  <= pop;
        end
    end

    // ------------------------------------------------
    // stage 2: range check and saturation
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (s1_valid_q) begin
            if (s1_diff_q[TOF_W] || (s1_diff_q > $signed({1'b0, range_i}))) begin
                res_tof_o <= TOF_OVERFLOW;
            end else begin
                res_tof_o <= s1_diff_q[TOF_W-1:0];
            end
            res_int_o <= (s1_pop_q > POP_W'(INT_MAX)) ? INT_MAX : s1_pop_q[INT_W-1:0];
        end
    end

    assign res_valid_o = s2_valid_q;

endmodule

/* logic/hit_capture.sv */
`timescale 1ns/1ps

module hit_capture
    import tdc_pkg::*;
#(
    parameter int MAX_HITS = 3
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                hit_i,
    input  logic [SPAD_W-1:0]   spad_en_i,
    input  logic [PHASE_W-1:0]  phase_i,
    input  logic                window_open_i,
    input  logic                window_close_i,
    input  logic [COARSE_W-1:0] coarse_i,
    output logic [NUM_W-1:0]    hit_count_o,
    output logic                count_valid_o,
    output logic                hit_valid_o,
    output logic [COARSE_W-1:0] hit_coarse_o,
    output logic [PHASE_W-1:0]  hit_phase_o,
    output logic [SPAD_W-1:0]   hit_spad_o
);

    logic [COARSE_W-1:0] coarse_mem [MAX_HITS];
    logic [PHASE_W-1:0]  phase_mem  [MAX_HITS];
    logic [SPAD_W-1:0]   spad_mem   [MAX_HITS];

    logic [NUM_W-1:0] cnt_q;
    logic [NUM_W-1:0] rd_idx_q;
    logic             count_valid_q;
    logic             replay_q;
    logic             take;

    // extra hits beyond MAX_HITS are dropped
    assign take = hit_i && window_open_i && (cnt_q < NUM_W'(MAX_HITS));

    // ------------------------------------------------
    // hit storage
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (take) begin
            coarse_mem[cnt_q] <= coarse_i;
            phase_mem[cnt_q]  <= phase_i;   // stop edge
            spad_mem[cnt_q]   <= spad_en_i;
        end
    end

    // ------------------------------------------------
    // count, report and replay
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q         <= '0;
            rd_idx_q      <= '0;
            count_valid_q <= 1'b0;
            replay_q      <= 1'b0;
        end else begin
            count_valid_q <= window_close_i;
            if (take) begin
                cnt_q <= cnt_q + 1'b1;
            end
            if (count_valid_q && (cnt_q != '0)) begin
                replay_q <= 1'b1;
                rd_idx_q <= '0;
            end
            if (replay_q) begin
                if (rd_idx_q == cnt_q - 1'b1) begin
                    replay_q <= 1'b0;
                    cnt_q    <= '0;  // ready for the next window
                end else begin
                    rd_idx_q <= rd_idx_q + 1'b1;
                end
            end
        end
    end

    assign hit_count_o   = cnt_q;
    assign count_valid_o = count_valid_q;
    assign hit_valid_o   = replay_q;
    assign hit_coarse_o  = coarse_mem[rd_idx_q];
    assign hit_phase_o   = phase_mem[rd_idx_q];
    assign hit_spad_o    = spad_mem[rd_idx_q];

    // replay is over before the next window opens
    a_replay_done: assert property (@(posedge clk) disable iff (!rst_n)
        window_open_i |-> !replay_q);

endmodule

/* logic/measure_window.sv */
`timescale 1ns/1ps

module measure_window
    import tdc_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_i,
    input  logic [TOF_W-1:0]    range_i,
    input  logic [PHASE_W-1:0]  phase_i,
    input  logic                busy_i,
    output logic                window_open_o,
    output logic [COARSE_W-1:0] coarse_o,
    output logic                window_close_o,
    output logic [TOF_W-1:0]    range_o,
    output logic [PHASE_W-1:0]  start_phase_o
);

    logic                open_q;
    logic [COARSE_W-1:0] coarse_q;
    logic [TOF_W-1:0]    range_q;
    logic [PHASE_W-1:0]  start_phase_q;
    logic                accept;

    assign accept = start_i && !open_q && !busy_i;  // start ignored otherwise

    // last coarse step of the window, a hit here still counts
    assign window_close_o = open_q && (coarse_q == range_q[TOF_W-1:FINE_W]);

    // ------------------------------------------------
    // coarse counter
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            open_q   <= 1'b0;
            coarse_q <= '0;
        end else if (accept) begin
            open_q   <= 1'b1;
            coarse_q <= '0;
        end else if (window_close_o) begin
            open_q   <= 1'b0;
        end else if (open_q) begin
            coarse_q <= coarse_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            range_q       <= range_i;
            start_phase_q <= phase_i;  // start edge of the TOF
        end
    end

    assign window_open_o = open_q;
    assign coarse_o      = coarse_q;
    assign range_o       = range_q;
    assign start_phase_o = start_phase_q;

    // no frame is being emitted while a window is open
    a_idle_while_open: assert property (@(posedge clk) disable iff (!rst_n)
        window_open_o |-> !busy_i);

endmodule

/* logic/phase_decoder.sv */
`timescale 1ns/1ps

module phase_decoder
    import tdc_pkg::*;
(
    input  logic [PHASE_W-1:0] phase_i,
    output logic [FINE_W-1:0]  fine_o
);

    logic [FINE_W:0] run_len;  // one extra bit, a full vector counts 32
    logic            in_run;

    // length of the run of ones starting at tap 0
    always_comb begin
        run_len = '0;
        in_run  = 1'b1;
        for (int i = 0; i < PHASE_W; i++) begin
            if (in_run && phase_i[i]) begin
                run_len = run_len + 1'b1;
            end else begin
                in_run = 1'b0;  // first zero ends the code
            end
        end
    end

    // saturate at the last tap
    always_comb begin
        if (run_len[FINE_W]) begin
            fine_o = '1;
        end else begin
            fine_o = run_len[FINE_W-1:0];
        end
    end

endmodule

/* logic/tdc_pkg.sv */
package tdc_pkg;

    // ------------------------------------------------
    // datapath widths
    // ------------------------------------------------
    parameter int PHASE_W  = 32;  // DLL taps
    parameter int FINE_W   = 5;   // fine code, one tap step
    parameter int COARSE_W = 10;  // coarse counter, one clock step
    parameter int TOF_W    = COARSE_W + FINE_W;
    parameter int SPAD_W   = 16;  // 4x4 pixel enables
    parameter int INT_W    = 4;
    parameter int NUM_W    = 2;   // hit count field

    // popcount of the SPAD enables needs one bit more than INT_W
    parameter int POP_W    = $clog2(SPAD_W + 1);

    // ------------------------------------------------
    // limits
    // ------------------------------------------------
    parameter logic [TOF_W-1:0] TOF_OVERFLOW = '1;  // out of range or no hit
    parameter logic [INT_W-1:0] INT_MAX      = 4'd15;

endpackage
